// File: design/arithPkg.sv
// Shared definitions for the arithmetic blocks: adder speed selection and a width helper.
// Referenced by scoped name from the multiplier-adder and its sub-blocks.
package arithPkg;

	// adder structure selection
	typedef enum logic [1:0] {
		SLOW = 2'b00,  // serial prefix, linear compressors
		FAST = 2'b10   // sklansky prefix, compressor trees
	} speedE;

	// floor(log2(n)), gives -1 for n < 1
	function automatic int log2Floor(input int n);
		int lvl;
		int pow;
		lvl = -1;
		pow = 1;
		while (pow <= n) begin
			lvl = lvl + 1;
			pow = pow * 2;
		end
		return lvl;
	endfunction

endpackage

// File: design/busPkg.sv
// Wishbone register map of the MAC peripheral, shared by the register block and the testbench.
// Word addresses, bit positions and the bus data width.
package busPkg;

	localparam int dataWidth = 32;  // wishbone data bus

	// word addresses
	localparam logic [2:0] regCtrl   = 3'd0;  // write only, reads zero
	localparam logic [2:0] regOpX    = 3'd1;  // multiplier operand
	localparam logic [2:0] regOpY    = 3'd2;  // multiplicand operand
	localparam logic [2:0] regAcc    = 3'd3;  // accumulator
	localparam logic [2:0] regStatus = 3'd4;  // read only

	// CTRL bits
	localparam int ctrlStart = 0;  // 1 requests one MAC step

	// STATUS bits
	localparam int statBusy = 0;
	localparam int statDone = 1;  // sticky until next accepted start

	// remaining addresses are unmapped
	// reads return zero there, writes are dropped

endpackage

// File: design/carrySaveTree.sv
// Multi-operand carry-save adder: reduces depth rows of width bits to one sum and one carry.
// Each column is an (m,2) compressor of full adders, chained (SLOW) or as a tree (FAST).
`timescale 1ns/1ns

module carrySaveTree #(
	parameter int             width = 8,               // row width
	parameter int             depth = 4,               // number of rows, >= 4
	parameter arithPkg::speedE speed = arithPkg::FAST
) (
	input  logic [depth*width-1:0] A,  // row k at [k*width +: width]
	output logic [width-1:0]       S,
	output logic [width-1:0]       C   // already shifted left by one
);

	logic [depth*width-1:0]         colBits;   // grouped by magnitude
	logic [(depth-3)*(width+1)-1:0] midCarry;  // column to column carries
	logic [width-1:0]               colCarry;  // unshifted final carries

	// transpose: column i holds bit i of every row
	always_comb begin
		for (int k = 0; k < depth; k++) begin
			for (int i = 0; i < width; i++) begin
				colBits[i*depth+k] = A[k*width+i];
			end
		end
	end

	assign midCarry[depth-4:0] = '0;  // nothing enters column 0

	for (genvar i = 0; i < width; i++) begin : gCol
		logic [3*depth-5:0] fifo;  // inputs, then sums and carry-ins interleaved
		logic [depth-3:0]   cin;
		logic [depth-3:0]   cout;
		assign fifo[depth-1:0] = colBits[i*depth +: depth];
		assign cin = {1'b0, midCarry[i*(depth-3) +: depth-3]};
		for (genvar j = 0; j < depth - 2; j++) begin : gCinSlot
			assign fifo[depth+2*j+1] = cin[j];
		end
		if (speed == arithPkg::SLOW) begin : gChain
			assign {cout[0], fifo[depth]} = fifo[0] + fifo[1] + fifo[2];  // first fa
			for (genvar j = 1; j < depth - 2; j++) begin : gFa
				// next input bit, one carry-in, previous sum
				assign {cout[j], fifo[depth+2*j]} =
					fifo[j+2] + fifo[depth+2*j-1] + fifo[depth+2*j-2];
			end
		end else begin : gTree
			for (genvar j = 0; j < depth - 2; j++) begin : gFa
				// consume three from the front, append sum at the back
				assign {cout[j], fifo[depth+2*j]} = fifo[3*j] + fifo[3*j+1] + fifo[3*j+2];
			end
		end
		assign S[i] = fifo[3*depth-6];
		assign colCarry[i] = cout[depth-3];
		assign midCarry[(i+1)*(depth-3) +: depth-3] = cout[depth-4:0];  // to next column
	end

	assign C = {colCarry[width-2:0], 1'b0};

endmodule

// File: design/macCore.sv
// MAC sequencer around the multiplier-adder: acc <= opX*opY + acc, one step per start.
// Start sampled at one edge latches the stage, the next edge writes back and sets done.
`timescale 1ns/1ns

module macCore #(
	parameter int             widthX = 8,
	parameter int             widthY = 8,
	parameter int             widthA = 20,
	parameter arithPkg::speedE speed  = arithPkg::FAST
) (
	input  logic              clk,
	input  logic              rst,
	input  logic [widthX-1:0] opX,
	input  logic [widthY-1:0] opY,
	input  logic              startReq,
	input  logic              accWr,
	input  logic [widthA-1:0] accWrData,
	output logic [widthA-1:0] acc,
	output logic              busy,
	output logic              done
);

	logic [widthX-1:0] stgX;   // stage operands
	logic [widthY-1:0] stgY;
	logic [widthA-1:0] stgA;   // acc as seen at start
	logic [widthA-1:0] macRes;
	logic              accept;

	assign accept = startReq && !busy;  // start while busy is lost

	mulAddSgn #(
		.widthX(widthX),
		.widthY(widthY),
		.widthA(widthA),
		.speed (speed)
	) uMulAdd (
		.X(stgX),
		.Y(stgY),
		.A(stgA),
		.P(macRes)
	);

	always_ff @(posedge clk) begin
		if (accept) begin
			stgX <= opX;
			stgY <= opY;
			stgA <= acc;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			acc  <= '0;
			busy <= 1'b0;
			done <= 1'b0;
		end else if (busy) begin
			acc  <= macRes;  // write back, wraps mod 2^widthA
			busy <= 1'b0;
			done <= 1'b1;
		end else if (accept) begin
			busy <= 1'b1;
			done <= 1'b0;    // cleared only by a new start
		end else if (accWr) begin
			acc <= accWrData;  // loads only when idle
		end
	end

endmodule

// File: design/macRegs.sv
// Wishbone classic slave for the MAC: operand registers, accumulator access, CTRL and STATUS.
// Acknowledges every request one cycle after it is seen; start and acc loads leave as pulses.
`timescale 1ns/1ns

module macRegs #(
	parameter int widthX = 8,
	parameter int widthY = 8,
	parameter int widthA = 20
) (
	input  logic                          clk,
	input  logic                          rst,
	input  logic                          wbCyc,
	input  logic                          wbStb,
	input  logic                          wbWe,
	input  logic [2:0]                    wbAdr,
	input  logic [busPkg::dataWidth-1:0]  wbDatI,
	output logic [busPkg::dataWidth-1:0]  wbDatO,
	output logic                          wbAck,
	output logic [widthX-1:0]             opX,
	output logic [widthY-1:0]             opY,
	output logic                          startReq,   // high in the ack cycle
	output logic                          accWr,      // high in the ack cycle
	output logic [widthA-1:0]             accWrData,
	input  logic [widthA-1:0]             acc,
	input  logic                          busy,
	input  logic                          done
);

	localparam int dw = busPkg::dataWidth;

	logic          req;     // request not yet acknowledged
	logic          wrEn;
	logic [dw-1:0] rdData;

	assign req  = wbCyc && wbStb && !wbAck;  // ack blocks a second pass
	assign wrEn = req && wbWe;

	// read mux, signed fields sign-extended to bus width
	always_comb begin
		rdData = '0;
		case (wbAdr)
			busPkg::regOpX: rdData = dw'(signed'(opX));
			busPkg::regOpY: rdData = dw'(signed'(opY));
			busPkg::regAcc: rdData = dw'(signed'(acc));
			busPkg::regStatus: begin
				rdData[busPkg::statBusy] = busy;
				rdData[busPkg::statDone] = done;
			end
			default: rdData = '0;  // CTRL and holes
		endcase
	end

	// handshake and pulses
	always_ff @(posedge clk) begin
		if (rst) begin
			wbAck    <= 1'b0;
			wbDatO   <= '0;
			startReq <= 1'b0;
			accWr    <= 1'b0;
		end else begin
			wbAck    <= req;
			wbDatO   <= (req && !wbWe) ? rdData : '0;  // data only with ack
			startReq <= wrEn && (wbAdr == busPkg::regCtrl) && wbDatI[busPkg::ctrlStart];
			accWr    <= wrEn && (wbAdr == busPkg::regAcc);  // core drops it if busy
		end
	end

	// operand and acc load data
	always_ff @(posedge clk) begin
		if (wrEn && (wbAdr == busPkg::regOpX)) begin
			opX <= wbDatI[widthX-1:0];
		end
		if (wrEn && (wbAdr == busPkg::regOpY)) begin
			opY <= wbDatI[widthY-1:0];
		end
		if (wrEn && (wbAdr == busPkg::regAcc)) begin
			accWrData <= wbDatI[widthA-1:0];  // truncated to acc width
		end
	end

endmodule

// File: design/macTop.sv
// Top level of the MAC peripheral: Wishbone register block beside the MAC core.
// Sets the operand, accumulator and speed parameters for both.
`timescale 1ns/1ns

module macTop #(
	parameter int             widthX = 8,   // <= widthY
	parameter int             widthY = 8,
	parameter int             widthA = 20,  // > widthX+widthY, <= 32
	parameter arithPkg::speedE speed  = arithPkg::FAST
) (
	input  logic                         clk,
	input  logic                         rst,
	input  logic                         wbCyc,
	input  logic                         wbStb,
	input  logic                         wbWe,
	input  logic [2:0]                   wbAdr,
	input  logic [busPkg::dataWidth-1:0] wbDatI,
	output logic [busPkg::dataWidth-1:0] wbDatO,
	output logic                         wbAck
);

	logic [widthX-1:0] opX;
	logic [widthY-1:0] opY;
	logic              startReq;
	logic              accWr;
	logic [widthA-1:0] accWrData;
	logic [widthA-1:0] acc;
	logic              busy;
	logic              done;

	macRegs #(.widthX(widthX), .widthY(widthY), .widthA(widthA)) uRegs (
		.clk(clk), .rst(rst),
		.wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe), .wbAdr(wbAdr),
		.wbDatI(wbDatI), .wbDatO(wbDatO), .wbAck(wbAck),
		.opX(opX), .opY(opY), .startReq(startReq),
		.accWr(accWr), .accWrData(accWrData),
		.acc(acc), .busy(busy), .done(done)
	);

	macCore #(.widthX(widthX), .widthY(widthY), .widthA(widthA), .speed(speed)) uCore (
		.clk(clk), .rst(rst),
		.opX(opX), .opY(opY), .startReq(startReq),
		.accWr(accWr), .accWrData(accWrData),
		.acc(acc), .busy(busy), .done(done)
	);

endmodule

// File: design/mulAddSgn.sv
// Signed multiplier-adder P = X*Y + A (mod 2^widthA), fully combinational.
// Baugh-Wooley rows, carry-save reduction, augend merge row and a prefix adder.
`timescale 1ns/1ns

module mulAddSgn #(
	parameter int             widthX = 8,   // <= widthY
	parameter int             widthY = 8,
	parameter int             widthA = 20,  // > widthX+widthY
	parameter arithPkg::speedE speed  = arithPkg::FAST
) (
	input  logic [widthX-1:0] X,
	input  logic [widthY-1:0] Y,
	input  logic [widthA-1:0] A,
	output logic [widthA-1:0] P
);

	localparam int widthP = widthX + widthY;

	logic [(widthX+2)*widthP-1:0] pp;
	logic [widthA-1:0]            sum1;   // product in carry-save form, extended
	logic [widthA-1:0]            cry1;
	logic [widthA-1:0]            sum2;   // after adding A
	logic [widthA-1:0]            cryRaw;
	logic [widthA-1:0]            cry2;

	mulPartialProducts #(.widthX(widthX), .widthY(widthY)) uPp (.X(X), .Y(Y), .PP(pp));

	carrySaveTree #(.width(widthP), .depth(widthX + 2), .speed(speed)) uTree (
		.A(pp),
		.S(sum1[widthP-1:0]),
		.C(cry1[widthP-1:0])
	);

	// sign extension of the carry-save pair
	assign sum1[widthP] = ~sum1[widthP-1];
	for (genvar i = widthP + 1; i < widthA; i++) begin : gSumExt
		assign sum1[i] = 1'b0;
	end
	assign cry1[widthA-1:widthP] = '1;  // constant ones absorb the msb weight

	// 3:2 row for the augend
	for (genvar i = 0; i < widthA; i++) begin : gCsa
		assign {cryRaw[i], sum2[i]} = A[i] + cry1[i] + sum1[i];
	end
	assign cry2 = {cryRaw[widthA-2:0], 1'b0};

	prefixAdder #(.width(widthA), .speed(speed)) uAdd (.A(sum2), .B(cry2), .S(P));

endmodule

// File: design/mulPartialProducts.sv
// Baugh-Wooley partial product generator for signed X times signed Y.
// Emits widthX+2 rows of widthX+widthY bits, two of them carrying sign corrections.
`timescale 1ns/1ns

module mulPartialProducts #(
	parameter int widthX = 8,  // multiplier width, <= widthY
	parameter int widthY = 8   // multiplicand width
) (
	input  logic [widthX-1:0]                     X,
	input  logic [widthY-1:0]                     Y,
	output logic [(widthX+2)*(widthX+widthY)-1:0] PP  // row r at [r*widthP +: widthP]
);

	localparam int widthP = widthX + widthY;  // one row

	always_comb begin
		logic [(widthX+2)*widthP-1:0] rows;
		rows = '0;
		// plain rows, negative-weight column inverted
		for (int i = 0; i < widthX - 1; i++) begin
			for (int k = 0; k < widthY - 1; k++) begin
				rows[i*widthP+i+k] = X[i] & Y[k];
			end
			rows[i*widthP+i+widthY-1] = ~X[i] & Y[widthY-1];
		end
		// sign row of X, inverted except for the msb product
		for (int k = 0; k < widthY - 1; k++) begin
			rows[(widthX-1)*widthP+widthX-1+k] = X[widthX-1] & ~Y[k];
		end
		rows[(widthX-1)*widthP+widthX+widthY-2] = X[widthX-1] & Y[widthY-1];
		// correction for the inverted X sign row
		rows[widthX*widthP+widthX-1]   = X[widthX-1];
		rows[widthX*widthP+widthP-2]   = ~X[widthX-1];
		// correction for the inverted Y sign column, plus the msb constant
		rows[(widthX+1)*widthP+widthY-1] = Y[widthY-1];
		rows[(widthX+1)*widthP+widthP-2] = ~Y[widthY-1];
		rows[(widthX+1)*widthP+widthP-1] = 1'b1;
		PP = rows;
	end

endmodule

// File: design/prefixAdder.sv
// Carry-propagate adder S = A + B (mod 2^width) built on a generate/propagate prefix network.
// SLOW gives a serial prefix chain, FAST a Sklansky tree of depth ceil(log2(width)).
`timescale 1ns/1ns

module prefixAdder #(
	parameter int             width = 8,
	parameter arithPkg::speedE speed = arithPkg::FAST
) (
	input  logic [width-1:0] A,
	input  logic [width-1:0] B,
	output logic [width-1:0] S
);

	localparam int lvls = arithPkg::log2Floor(width - 1) + 1;  // sklansky levels

	logic [width-1:0] gen;   // and-or prefix inputs
	logic [width-1:0] prop;
	logic [width-1:0] halfSum;
	logic [width-1:0] gOut;  // carry out of bit i

	assign gen     = A & B;
	assign prop    = A | B;
	assign halfSum = A ^ B;

	if (speed == arithPkg::SLOW) begin : gSerial
		logic [width-1:0] gChain;
		assign gChain[0] = gen[0];
		for (genvar i = 1; i < width; i++) begin : gBit
			assign gChain[i] = gen[i] | (prop[i] & gChain[i-1]);  // ripple
		end
		assign gOut = gChain;
	end else begin : gSklansky
		logic [lvls:0][width-1:0] gTmp;  // one row per level
		logic [lvls:0][width-1:0] pTmp;
		assign gTmp[0] = gen;
		assign pTmp[0] = prop;
		for (genvar l = 1; l <= lvls; l++) begin : gLvl
			for (genvar j = 0; j < width; j++) begin : gBit
				localparam int span = 2 ** l;
				localparam int half = 2 ** (l - 1);
				localparam int src  = j - (j % span) + half - 1;  // top of lower half
				if ((j % span) >= half) begin : gBlack
					assign gTmp[l][j] = gTmp[l-1][j] | (pTmp[l-1][j] & gTmp[l-1][src]);
					assign pTmp[l][j] = pTmp[l-1][j] & pTmp[l-1][src];
				end else begin : gWhite
					assign gTmp[l][j] = gTmp[l-1][j];  // pass through
					assign pTmp[l][j] = pTmp[l-1][j];
				end
			end
		end
		assign gOut = gTmp[lvls];
	end

	assign S = halfSum ^ {gOut[width-2:0], 1'b0};  // carry into bit 0 is zero

endmodule

// File: sources.f
design/arithPkg.sv
design/busPkg.sv
design/mulPartialProducts.sv
design/carrySaveTree.sv
design/prefixAdder.sv
design/mulAddSgn.sv
design/macRegs.sv
design/macCore.sv
design/macTop.sv
testbench/tbClock.sv
testbench/macAssertions.sv
testbench/macTb.sv

// File: testbench/macAssertions.sv
// Concurrent checks on the Wishbone handshake and the core status flags.
// Bound into the register block, which sees the bus and the core's busy/done.
`timescale 1ns/1ns

module macAssertions (
	input logic clk,
	input logic rst,
	input logic wbCyc,
	input logic wbStb,
	input logic wbAck,
	input logic busy,
	input logic done
);

	// ack is a one-cycle pulse
	ackPulse: assert property (@(posedge clk) disable iff (rst) wbAck |=> !wbAck)
		else $error("wbAck held high for more than one cycle");

	// ack answers a request seen on the edge before
	ackAfterReq: assert property (@(posedge clk) disable iff (rst)
		wbAck |-> $past(wbCyc && wbStb))
		else $error("wbAck raised without a preceding request");

	statusExclusive: assert property (@(posedge clk) disable iff (rst) !(busy && done))
		else $error("busy and done high together");

	// done comes with write-back only
	doneOnBusyFall: assert property (@(posedge clk) disable iff (rst) $rose(done) |-> $fell(busy))
		else $error("done rose without busy falling");

endmodule

bind macRegs macAssertions uChecks (
	.clk(clk), .rst(rst),
	.wbCyc(wbCyc), .wbStb(wbStb), .wbAck(wbAck),
	.busy(busy), .done(done)
);

// File: testbench/macTb.sv
// Wishbone testbench for the MAC peripheral that checks every read of macTop
// against a reference model of ACC = X*Y + ACC wrapping at the accumulator width.
`timescale 1ns/1ns

module macTb;

	localparam int widthX     = 8;
	localparam int widthY     = 8;
	localparam int widthA     = 20;
	localparam int dw         = busPkg::dataWidth;
	localparam int ackLimit   = 20;  // cycles per bus access
	localparam int doneLimit  = 20;  // status polls per operation
	localparam int drainLimit = 10;
	localparam logic [dw-1:0] startWord = dw'(1) << busPkg::ctrlStart;

	logic          clk;
	logic          rst;
	logic          wbCyc;
	logic          wbStb;
	logic          wbWe;
	logic [2:0]    wbAdr;
	logic [dw-1:0] wbDatI;
	logic [dw-1:0] wbDatO;
	logic          wbAck;

	int            seed;
	logic [dw-1:0] accModel;  // expected ACC sign-extended

	// pending checks for the compare process
	string         nameQ[$];
	logic [dw-1:0] expQ[$];
	logic [dw-1:0] actQ[$];
	bit            flagQ[$];

	tbClock #(.period(100), .rstCycles(3)) uClk (.clk(clk), .rst(rst));

	macTop #(.widthX(widthX), .widthY(widthY), .widthA(widthA), .speed(arithPkg::FAST)) UUT (
		.clk(clk), .rst(rst),
		.wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe), .wbAdr(wbAdr),
		.wbDatI(wbDatI), .wbDatO(wbDatO), .wbAck(wbAck)
	);

	// low w bits read as a signed number
	function automatic longint lowSigned(input logic [63:0] v, input int w);
		longint t;
		t = longint'(v) <<< (64 - w);
		return t >>> (64 - w);
	endfunction

	function automatic logic [dw-1:0] maxOf(input int w);
		return (dw'(1) << (w - 1)) - 1;
	endfunction

	function automatic logic [dw-1:0] minOf(input int w);
		return ~maxOf(w);  // sign-extended most negative
	endfunction

	// expected ACC after one step as read over the bus
	function automatic logic [dw-1:0] macRef(input logic [dw-1:0] x, input logic [dw-1:0] y,
			input logic [dw-1:0] a);
		longint r;
		r = lowSigned(x, widthX) * lowSigned(y, widthY) + lowSigned(a, widthA);
		return dw'(lowSigned(r, widthA));  // wrap then sign-extend
	endfunction

	task automatic abortRun(input string why);
		$display("%s", why);
		$display("Simulation finished: FAIL");
		$fatal(1, "run stopped");
	endtask

	task automatic checkData(input string name, input logic [dw-1:0] exp,
			input logic [dw-1:0] act);
		if (act !== exp) begin
			abortRun($sformatf("ERR %s: expected 0x%08h, actual 0x%08h", name, exp, act));
		end
	endtask

	task automatic checkFlag(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			abortRun($sformatf("ERR %s: expected %b, actual %b", name, exp, act));
		end
	endtask

	task automatic expectData(input string name, input logic [dw-1:0] exp,
			input logic [dw-1:0] act);
		nameQ.push_back(name);
		expQ.push_back(exp);
		actQ.push_back(act);
		flagQ.push_back(1'b0);
	endtask

	task automatic expectFlag(input string name, input logic exp, input logic act);
		nameQ.push_back(name);
		expQ.push_back(dw'(exp));
		actQ.push_back(dw'(act));
		flagQ.push_back(1'b1);
	endtask

	// compare process
	always @(posedge clk) begin
		while (nameQ.size() > 0) begin
			if (flagQ[0]) begin
				checkFlag(nameQ[0], expQ[0][0], actQ[0][0]);
			end else begin
				checkData(nameQ[0], expQ[0], actQ[0]);
			end
			void'(nameQ.pop_front());
			void'(expQ.pop_front());
			void'(actQ.pop_front());
			void'(flagQ.pop_front());
		end
	end

	task automatic waitAck(input logic [2:0] adr);
		int n;
		n = 0;
		@(posedge clk);
		#1;  // ack settles after the edge
		while (!wbAck) begin
			n++;
			if (n >= ackLimit) begin
				abortRun($sformatf("bus hung: no wbAck for address %0d", adr));
			end
			@(posedge clk);
			#1;
		end
	endtask

	// drop the strobe and leave one idle cycle
	task automatic releaseBus();
		#4;
		wbCyc = 1'b0;
		wbStb = 1'b0;
		wbWe  = 1'b0;
		@(posedge clk);
		#5;
	endtask

	task automatic wbWrite(input logic [2:0] adr, input logic [dw-1:0] dat);
		wbCyc  = 1'b1;
		wbStb  = 1'b1;
		wbWe   = 1'b1;
		wbAdr  = adr;
		wbDatI = dat;
		waitAck(adr);
		releaseBus();
	endtask

	task automatic wbRead(input logic [2:0] adr, output logic [dw-1:0] rd);
		wbCyc = 1'b1;
		wbStb = 1'b1;
		wbWe  = 1'b0;
		wbAdr = adr;
		waitAck(adr);
		rd = wbDatO;  // valid with ack
		releaseBus();
	endtask

	task automatic pollDone(input string name);
		logic [dw-1:0] st;
		int            n;
		n = 0;
		wbRead(busPkg::regStatus, st);
		while (!st[busPkg::statDone]) begin
			n++;
			if (n >= doneLimit) begin
				abortRun($sformatf("%s: core never reported done", name));
			end
			wbRead(busPkg::regStatus, st);
		end
		expectFlag({name, " busy"}, 1'b0, st[busPkg::statBusy]);
	endtask

	task automatic loadAcc(input logic [dw-1:0] v);
		wbWrite(busPkg::regAcc, v);
		accModel = dw'(lowSigned(v, widthA));  // truncated to acc width
	endtask

	task automatic runMac(input string name, input logic [dw-1:0] x, input logic [dw-1:0] y);
		logic [dw-1:0] got;
		wbWrite(busPkg::regOpX, x);
		wbWrite(busPkg::regOpY, y);
		wbWrite(busPkg::regCtrl, startWord);
		pollDone(name);
		accModel = macRef(x, y, accModel);
		wbRead(busPkg::regAcc, got);
		expectData(name, accModel, got);
	endtask

	initial begin : stimulus
		logic [dw-1:0] v;
		logic [dw-1:0] x;
		logic [dw-1:0] y;
		logic [dw-1:0] got;
		int            n;
		seed      = 32'hc291;
		accModel  = '0;
		wbCyc     = 1'b0;
		wbStb     = 1'b0;
		wbWe      = 1'b0;
		wbAdr     = '0;
		wbDatI    = '0;

		n = 0;
		@(posedge clk);
		while (rst) begin
			n++;
			if (n > 10) begin
				abortRun("reset was never released");
			end
			@(posedge clk);
		end
		#5;

		// state straight out of reset
		wbRead(busPkg::regStatus, got);
		expectFlag("reset busy", 1'b0, got[busPkg::statBusy]);
		expectFlag("reset done", 1'b0, got[busPkg::statDone]);
		wbRead(busPkg::regAcc, got);
		expectData("reset acc", '0, got);

		// register readback with full 32-bit writes
		v = $random(seed);
		wbWrite(busPkg::regOpX, v);
		wbRead(busPkg::regOpX, got);
		expectData("opx readback", dw'(lowSigned(v, widthX)), got);
		v = $random(seed);
		wbWrite(busPkg::regOpY, v);
		wbRead(busPkg::regOpY, got);
		expectData("opy readback", dw'(lowSigned(v, widthY)), got);
		loadAcc($random(seed));
		wbRead(busPkg::regAcc, got);
		expectData("acc readback", accModel, got);
		wbRead(busPkg::regCtrl, got);
		expectData("ctrl reads zero", '0, got);
		for (int a = 5; a < 8; a++) begin
			wbWrite(3'(a), $random(seed));  // dropped
			wbRead(3'(a), got);
			expectData($sformatf("unmapped %0d", a), '0, got);
		end
		wbRead(busPkg::regAcc, got);
		expectData("acc after unmapped writes", accModel, got);

		// one step
		loadAcc($random(seed));
		runMac("single op", $random(seed), $random(seed));

		// running sum without acc reloads
		for (int i = 0; i < 50; i++) begin
			runMac($sformatf("chain %0d", i), $random(seed), $random(seed));
		end

		// sign-correction corners
		loadAcc(maxOf(widthA));
		runMac("min x min, acc max", minOf(widthX), minOf(widthY));
		loadAcc(minOf(widthA));
		runMac("min x min, acc min", minOf(widthX), minOf(widthY));
		loadAcc(maxOf(widthA));
		runMac("zero x min", '0, minOf(widthY));
		loadAcc(minOf(widthA));
		runMac("min x zero", minOf(widthX), '0);
		loadAcc(minOf(widthA));
		runMac("-1 x max, acc min", '1, maxOf(widthY));
		loadAcc(maxOf(widthA));
		runMac("-1 x max, acc max", '1, maxOf(widthY));
		runMac("max x max", maxOf(widthX), maxOf(widthY));

		// accesses right behind a start
		loadAcc($random(seed));
		x = $random(seed);
		y = $random(seed);
		wbWrite(busPkg::regOpX, x);
		wbWrite(busPkg::regOpY, y);
		wbWrite(busPkg::regCtrl, startWord);
		wbRead(busPkg::regStatus, got);
		expectFlag("busy after start", 1'b1, got[busPkg::statBusy]);
		expectFlag("done while busy", 1'b0, got[busPkg::statDone]);
		v = $random(seed);
		wbWrite(busPkg::regOpX, v);  // stage already holds x
		accModel = macRef(x, y, accModel);
		wbRead(busPkg::regAcc, got);
		expectData("first op kept", accModel, got);
		loadAcc($random(seed));
		wbWrite(busPkg::regCtrl, startWord);
		pollDone("second start");
		accModel = macRef(v, y, accModel);
		wbRead(busPkg::regAcc, got);
		expectData("second start", accModel, got);

		// let the compare process catch up
		n = 0;
		while (nameQ.size() > 0) begin
			n++;
			if (n > drainLimit) begin
				abortRun("compare queue never drained");
			end
			@(posedge clk);
			#5;
		end

		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

// File: testbench/tbClock.sv
// Clock and reset source for the MAC testbench.
// Free-running clock, reset held high over the first few rising edges.
`timescale 1ns/1ns

module tbClock #(
	parameter int period    = 100,  // ns
	parameter int rstCycles = 3
) (
	output logic clk,
	output logic rst
);

	initial begin
		clk = 1'b0;
		forever #(period / 2) clk = ~clk;
	end

	initial begin
		rst = 1'b1;
		repeat (rstCycles) @(posedge clk);
		#5 rst = 1'b0;  // released off the edge, like the bus inputs
	end

endmodule
